// ==== Makefile ====
TOP = controlUnitTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)
	verilator --lint-only -f sim.f --top-module controlUnit

obj_dir/V$(TOP): sim.f design/*.sv sim/*.sv include/*.svh
	verilator --binary -f sim.f --top-module $(TOP) -o V$(TOP)

# $fatal gives a non-zero exit status, so make fails with the run
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
    import rvCtrlPkg::*;
(
    input  logic          CLK,
    input  logic          reset,
    input  instrWord_t    instr,    // held by the IR for the whole instruction
    input  cmpResult_t    cmp,
    output datapathCtrl_t ctrl,
    output phaseStrobes_t strobes,
    output cpuPhase_t     phase
);

    instrClass_t iClass;

    // combinational decode of the held instruction
    instrDecoder u_decoder (
        .instr  (instr),
        .cmp    (cmp),
        .ctrl   (ctrl),
        .iClass (iClass)
    );

    phaseSequencer u_sequencer (
        .CLK     (CLK),
        .reset   (reset),
        .iClass  (iClass),
        .phase   (phase),
        .strobes (strobes)
    );

endmodule

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import rvCtrlPkg::*;
(
    input  instrWord_t    instr,
    input  cmpResult_t    cmp,
    output datapathCtrl_t ctrl,
    output instrClass_t   iClass
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          altOp;
    logic          brTaken;
    datapathCtrl_t dec;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct3 = instr[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = instr[FUNCT7_MSB:FUNCT7_LSB];
    assign altOp  = funct7[FUNCT7_ALT];

    // branch condition from the comparator
    always_comb
    begin
        case (funct3)
            F3_BEQ:          brTaken = (cmp == CMP_EQ);
            F3_BNE:          brTaken = (cmp != CMP_EQ);
            F3_BLT, F3_BLTU: brTaken = (cmp == CMP_LT);
            F3_BGE, F3_BGEU: brTaken = (cmp == CMP_GT) || (cmp == CMP_EQ);
            default:         brTaken = 1'b0;
        endcase
    end

    always_comb
    begin
        dec    = CTRL_DEFAULT;
        iClass = CL_INVALID;
        case (opcode)
            OP_R:
            begin
                iClass = CL_ALU;    // all eight funct3 codes defined
                case (funct3)
                    F3_ADD:  dec.aluOp = altOp ? SUB : ADD;
                    F3_SLL:  dec.aluOp = SLL;
                    F3_SLT:  dec.regDst = RD_CMP;
                    F3_SLTU:
                    begin
                        dec.regDst = RD_CMP;
                        dec.sign   = 1'b0;
                    end
                    F3_XOR:  dec.aluOp = XOR;
                    F3_SR:   dec.aluOp = altOp ? SRA : SRL;
                    F3_OR:   dec.aluOp = OR;
                    F3_AND:  dec.aluOp = AND;
                endcase
            end

            OP_IMM:
            begin
                iClass      = CL_ALU;
                dec.alu2Src = 1'b1;
                case (funct3)
                    F3_ADD:  dec.aluOp = ADD;
                    F3_SLL:
                    begin
                        dec.aluOp  = SLL;
                        dec.extSel = EXT_SHAMT;
                    end
                    F3_SLT:  dec.regDst = RD_CMP;
                    F3_SLTU:
                    begin
                        dec.regDst = RD_CMP;
                        dec.sign   = 1'b0;
                    end
                    F3_XOR:  dec.aluOp = XOR;
                    F3_SR:
                    begin
                        dec.aluOp  = altOp ? SRA : SRL;
                        dec.extSel = EXT_SHAMT;
                    end
                    F3_OR:   dec.aluOp = OR;
                    F3_AND:  dec.aluOp = AND;
                endcase
            end

            OP_LOAD:
            begin
                case (funct3)
                    F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU:
                    begin
                        iClass      = CL_LOAD;
                        dec.alu2Src = 1'b1;
                        dec.regDst  = RD_MEM;
                        dec.width   = accessWidth_t'(funct3[1:0]);
                        dec.sign    = ~funct3[2];   // lbu / lhu zero extend
                    end
                    default: iClass = CL_INVALID;
                endcase
            end

            OP_STORE:
            begin
                case (funct3)
                    F3_SB, F3_SH, F3_SW:
                    begin
                        iClass      = CL_STORE;
                        dec.alu2Src = 1'b1;     // rs1 + offset
                        dec.extSel  = EXT_S;
                        dec.width   = accessWidth_t'(funct3[1:0]);
                    end
                    default: iClass = CL_INVALID;
                endcase
            end

            OP_BRANCH:
            begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU:
                    begin
                        iClass      = CL_BRANCH;
                        dec.pcSrc   = brTaken;
                        dec.alu1Src = 1'b1;
                        dec.alu2Src = 1'b1;
                        dec.extSel  = EXT_B;
                        dec.sign    = ~funct3[1];   // unsigned compare for bltu/bgeu
                    end
                    default: iClass = CL_INVALID;
                endcase
            end

            OP_JAL:
            begin
                iClass      = CL_JUMP;
                dec.pcSrc   = 1'b1;
                dec.alu1Src = 1'b1;
                dec.alu2Src = 1'b1;
                dec.extSel  = EXT_J;
                dec.regDst  = RD_PC4;
            end

            OP_JALR:
            begin
                if (funct3 == F3_JALR)
                begin
                    iClass      = CL_JUMP;
                    dec.pcSrc   = 1'b1;
                    dec.alu2Src = 1'b1;     // rs1 + offset
                    dec.regDst  = RD_PC4;
                end
            end

            OP_LUI:
            begin
                iClass     = CL_UPPER;
                dec.immRes = 1'b1;
                dec.extSel = EXT_U;
            end

            OP_AUIPC:
            begin
                iClass      = CL_UPPER;
                dec.alu1Src = 1'b1;
                dec.alu2Src = 1'b1;
                dec.extSel  = EXT_U;
            end

            default: iClass = CL_INVALID;
        endcase
    end

    assign ctrl = dec;

endmodule

// ==== design/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer
    import rvCtrlPkg::*;
(
    input  logic          CLK,
    input  logic          reset,
    input  instrClass_t   iClass,
    output cpuPhase_t     phase,
    output phaseStrobes_t strobes
);

    cpuPhase_t nextPhase;

    always_ff @(posedge CLK)
    begin
        if (reset)
            phase <= P_IF;
        else
            phase <= nextPhase;
    end

    // one phase per clock, path set by class
    always_comb
    begin
        case (phase)
            P_IF:  nextPhase = P_ID;
            P_ID:  nextPhase = P_EXE;
            P_EXE:
            begin
                case (iClass)
                    CL_BRANCH, CL_INVALID: nextPhase = P_IF;
                    CL_LOAD, CL_STORE:     nextPhase = P_MEM;
                    default:               nextPhase = P_WB;
                endcase
            end
            P_MEM:
            begin
                if (iClass == CL_LOAD)
                    nextPhase = P_WB;
                else
                    nextPhase = P_IF;   // store done
            end
            P_WB:  nextPhase = P_IF;
            default: nextPhase = P_IF;
        endcase
    end

    // pcWr and irWr fire in the last cycle of an instruction
    always_comb
    begin
        strobes = '0;
        if (!reset)
        begin
            strobes.pcWr   = (nextPhase == P_IF);
            strobes.irWr   = (nextPhase == P_IF) || (phase == P_ID);
            strobes.regWr  = (phase == P_WB);
            strobes.dataWr = (phase == P_MEM) && (iClass == CL_STORE);
        end
    end

endmodule

// ==== design/rvCtrlPkg.sv ====
package rvCtrlPkg;

    typedef logic [31:0] instrWord_t;

    // instruction field bounds
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;
    localparam int FUNCT7_ALT = 5;    // funct7 bit picking sub / sra

    // major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3 for R-type and I-type ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    typedef enum logic [1:0] {
        CMP_EQ = 2'b00,
        CMP_LT = 2'b01,
        CMP_GT = 2'b10
    } cmpResult_t;

    typedef enum logic [2:0] {
        ADD = 3'b000,
        SUB = 3'b001,
        XOR = 3'b010,
        OR  = 3'b011,
        AND = 3'b100,
        SLL = 3'b101,
        SRL = 3'b110,
        SRA = 3'b111
    } aluOp_t;

    typedef enum logic [2:0] {
        EXT_I     = 3'b000,
        EXT_S     = 3'b001,
        EXT_B     = 3'b010,
        EXT_U     = 3'b011,
        EXT_J     = 3'b100,
        EXT_SHAMT = 3'b101
    } extSel_t;

    typedef enum logic [1:0] {
        RD_ALU = 2'b00,
        RD_MEM = 2'b01,
        RD_PC4 = 2'b10,
        RD_CMP = 2'b11
    } regDst_t;

    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b10
    } accessWidth_t;

    typedef enum logic [2:0] {
        CL_ALU     = 3'd0,
        CL_LOAD    = 3'd1,
        CL_STORE   = 3'd2,
        CL_BRANCH  = 3'd3,
        CL_JUMP    = 3'd4,
        CL_UPPER   = 3'd5,
        CL_INVALID = 3'd6
    } instrClass_t;

    typedef enum logic [2:0] {
        P_IF  = 3'b000,
        P_ID  = 3'b001,
        P_EXE = 3'b010,
        P_WB  = 3'b011,
        P_MEM = 3'b100
    } cpuPhase_t;

    typedef struct packed {
        logic         pcSrc;     // 1 selects the ALU target
        aluOp_t       aluOp;
        logic         alu1Src;   // 0 rs1, 1 PC
        logic         alu2Src;   // 0 rs2, 1 immediate
        regDst_t      regDst;
        extSel_t      extSel;
        logic         sign;
        accessWidth_t width;
        logic         immRes;    // immediate straight to rd
    } datapathCtrl_t;

    typedef struct packed {
        logic pcWr;
        logic irWr;
        logic regWr;
        logic dataWr;
    } phaseStrobes_t;

    // value of every control field unless an instruction overrides it
    localparam datapathCtrl_t CTRL_DEFAULT = '{
        pcSrc:   1'b0,
        aluOp:   ADD,
        alu1Src: 1'b0,
        alu2Src: 1'b0,
        regDst:  RD_ALU,
        extSel:  EXT_I,
        sign:    1'b1,
        width:   W_WORD,
        immRes:  1'b0
    };

endpackage

// ==== sim.f ====
+incdir+include
design/rvCtrlPkg.sv
design/instrDecoder.sv
design/phaseSequencer.sv
design/controlUnit.sv
sim/controlUnitTb.sv

// ==== include/ctrlVectors.svh ====
`ifndef CTRL_VECTORS_SVH
`define CTRL_VECTORS_SVH

typedef struct packed {
    instrWord_t    instr;
    cmpResult_t    cmp;
    datapathCtrl_t ctrl;      // expected controls
    instrClass_t   iClass;    // selects the expected phase path
    logic [2:0]    cycles;    // IF to next IF
} ctrlVector_t;

localparam int NUM_VECTORS = 51;

localparam ctrlVector_t CTRL_VECTORS [NUM_VECTORS] = '{
    // add sub sll slt sltu xor srl sra or and
    '{32'h00000033, CMP_EQ, '{'0, ADD, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h40000033, CMP_LT, '{'0, SUB, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00001033, CMP_EQ, '{'0, SLL, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00002033, CMP_LT, '{'0, ADD, '0, '0, RD_CMP, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00003033, CMP_GT, '{'0, ADD, '0, '0, RD_CMP, EXT_I, '0, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00004033, CMP_EQ, '{'0, XOR, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00005033, CMP_EQ, '{'0, SRL, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h40005033, CMP_EQ, '{'0, SRA, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00006033, CMP_EQ, '{'0, OR, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00007033, CMP_EQ, '{'0, AND, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    // addi slli slti sltiu xori srli srai ori andi
    '{32'h00000013, CMP_EQ, '{'0, ADD, '0, '1, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00001013, CMP_EQ, '{'0, SLL, '0, '1, RD_ALU, EXT_SHAMT, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00002013, CMP_LT, '{'0, ADD, '0, '1, RD_CMP, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00003013, CMP_GT, '{'0, ADD, '0, '1, RD_CMP, EXT_I, '0, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00004013, CMP_EQ, '{'0, XOR, '0, '1, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00005013, CMP_EQ, '{'0, SRL, '0, '1, RD_ALU, EXT_SHAMT, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h40005013, CMP_EQ, '{'0, SRA, '0, '1, RD_ALU, EXT_SHAMT, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00006013, CMP_EQ, '{'0, OR, '0, '1, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    '{32'h00007013, CMP_EQ, '{'0, AND, '0, '1, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_ALU, 3'd4},
    // lb lh lw lbu lhu
    '{32'h00000003, CMP_EQ, '{'0, ADD, '0, '1, RD_MEM, EXT_I, '1, W_BYTE, '0}, CL_LOAD, 3'd5},
    '{32'h00001003, CMP_EQ, '{'0, ADD, '0, '1, RD_MEM, EXT_I, '1, W_HALF, '0}, CL_LOAD, 3'd5},
    '{32'h00002003, CMP_EQ, '{'0, ADD, '0, '1, RD_MEM, EXT_I, '1, W_WORD, '0}, CL_LOAD, 3'd5},
    '{32'h00004003, CMP_EQ, '{'0, ADD, '0, '1, RD_MEM, EXT_I, '0, W_BYTE, '0}, CL_LOAD, 3'd5},
    '{32'h00005003, CMP_EQ, '{'0, ADD, '0, '1, RD_MEM, EXT_I, '0, W_HALF, '0}, CL_LOAD, 3'd5},
    // sb sh sw
    '{32'h00000023, CMP_EQ, '{'0, ADD, '0, '1, RD_ALU, EXT_S, '1, W_BYTE, '0}, CL_STORE, 3'd4},
    '{32'h00001023, CMP_EQ, '{'0, ADD, '0, '1, RD_ALU, EXT_S, '1, W_HALF, '0}, CL_STORE, 3'd4},
    '{32'h00002023, CMP_EQ, '{'0, ADD, '0, '1, RD_ALU, EXT_S, '1, W_WORD, '0}, CL_STORE, 3'd4},
    // beq bne blt bge bltu bgeu, each with EQ LT GT
    '{32'h00000063, CMP_EQ, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00000063, CMP_LT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00000063, CMP_GT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00001063, CMP_EQ, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00001063, CMP_LT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00001063, CMP_GT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00004063, CMP_EQ, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00004063, CMP_LT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00004063, CMP_GT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00005063, CMP_EQ, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00005063, CMP_LT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00005063, CMP_GT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '1, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00006063, CMP_EQ, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00006063, CMP_LT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00006063, CMP_GT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00007063, CMP_EQ, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00007063, CMP_LT, '{'0, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    '{32'h00007063, CMP_GT, '{'1, ADD, '1, '1, RD_ALU, EXT_B, '0, W_WORD, '0}, CL_BRANCH, 3'd3},
    // jal jalr lui auipc
    '{32'h0000006F, CMP_GT, '{'1, ADD, '1, '1, RD_PC4, EXT_J, '1, W_WORD, '0}, CL_JUMP, 3'd4},
    '{32'h00000067, CMP_LT, '{'1, ADD, '0, '1, RD_PC4, EXT_I, '1, W_WORD, '0}, CL_JUMP, 3'd4},
    '{32'h00000037, CMP_EQ, '{'0, ADD, '0, '0, RD_ALU, EXT_U, '1, W_WORD, '1}, CL_UPPER, 3'd4},
    '{32'h00000017, CMP_EQ, '{'0, ADD, '1, '1, RD_ALU, EXT_U, '1, W_WORD, '0}, CL_UPPER, 3'd4},
    // unknown opcode, then a load with an unused funct3
    '{32'h0000007F, CMP_EQ, '{'0, ADD, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_INVALID, 3'd3},
    '{32'h00003003, CMP_EQ, '{'0, ADD, '0, '0, RD_ALU, EXT_I, '1, W_WORD, '0}, CL_INVALID, 3'd3}
};

`endif

// ==== sim/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb
    import rvCtrlPkg::*;
();

    `include "ctrlVectors.svh"

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int CHECK_DELAY  = 10;    // after the falling edge drive
    localparam int WATCHDOG_NS  =
        2 * (NUM_VECTORS * 5 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);

    localparam logic [31:0] REG_FIELDS = 32'h01FF_8F80;    // rs2, rs1, rd

    logic          CLK;
    logic          reset;
    instrWord_t    instr;
    cmpResult_t    cmp;
    datapathCtrl_t ctrl;
    phaseStrobes_t strobes;
    cpuPhase_t     phase;

    controlUnit u_dut (
        .CLK     (CLK),
        .reset   (reset),
        .instr   (instr),
        .cmp     (cmp),
        .ctrl    (ctrl),
        .strobes (strobes),
        .phase   (phase)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic checkEq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic cpuPhase_t expectedPhase(input instrClass_t cls, input int step);
        cpuPhase_t p;
        case (step)
            0: p = P_IF;
            1: p = P_ID;
            2: p = P_EXE;
            3:
            begin
                if (cls == CL_LOAD || cls == CL_STORE)
                    p = P_MEM;
                else
                    p = P_WB;
            end
            default: p = P_WB;    // load write-back
        endcase
        return p;
    endfunction

    function automatic instrWord_t withRandomRegs(input instrWord_t word);
        logic [31:0] r;
        r = $urandom;
        return (word & ~REG_FIELDS) | (r & REG_FIELDS);
    endfunction

    // called on a falling edge, returns on the falling edge of the next IF
    task automatic applyVector(input int idx);
        ctrlVector_t   v;
        int            len;
        int            step;
        cpuPhase_t     p;
        phaseStrobes_t expS;
        v   = CTRL_VECTORS[idx];
        len = int'(v.cycles);
        if (v.instr[6:0] == OP_BRANCH)
            instr = v.instr;
        else
            instr = withRandomRegs(v.instr);
        cmp = v.cmp;
        for (step = 0; step < len; step++)
        begin
            #(CHECK_DELAY);
            p           = expectedPhase(v.iClass, step);
            expS.pcWr   = (step == len - 1);
            expS.irWr   = (step == len - 1) || (p == P_ID);
            expS.regWr  = (p == P_WB);
            expS.dataWr = (p == P_MEM) && (v.iClass == CL_STORE);
            checkEq("phase", 32'(phase), 32'(p));
            checkEq("pcWr", 32'(strobes.pcWr), 32'(expS.pcWr));
            checkEq("irWr", 32'(strobes.irWr), 32'(expS.irWr));
            checkEq("regWr", 32'(strobes.regWr), 32'(expS.regWr));
            checkEq("dataWr", 32'(strobes.dataWr), 32'(expS.dataWr));
            checkEq("ctrl", 32'(ctrl), 32'(v.ctrl));
            @(negedge CLK);
        end
    endtask

    // sync reset taken in ID, where irWr is otherwise high
    task automatic resetMidInstruction();
        instr = withRandomRegs(32'h00002023);    // sw
        cmp   = CMP_EQ;
        #(CHECK_DELAY);
        checkEq("phase", 32'(phase), 32'(P_IF));    // last vector handed back to fetch
        @(negedge CLK);
        reset = 1'b1;
        #(CHECK_DELAY);
        checkEq("phase", 32'(phase), 32'(P_ID));
        checkEq("strobes", 32'(strobes), 32'd0);
        @(negedge CLK);
        #(CHECK_DELAY);
        checkEq("phase", 32'(phase), 32'(P_IF));    // EXE skipped
        checkEq("strobes", 32'(strobes), 32'd0);
        @(negedge CLK);
        reset = 1'b0;
        #(CHECK_DELAY);
        checkEq("phase", 32'(phase), 32'(P_IF));
        checkEq("strobes", 32'(strobes), 32'd0);
        @(negedge CLK);
        #(CHECK_DELAY);
        checkEq("phase", 32'(phase), 32'(P_ID));
    endtask

    initial
    begin
        void'($urandom(32'h9ba1_cb64));
        reset = 1'b1;
        instr = '0;
        cmp   = CMP_EQ;

        repeat (RESET_CYCLES - 1)
        begin
            @(negedge CLK);
            #(CHECK_DELAY);
            checkEq("phase", 32'(phase), 32'(P_IF));
            checkEq("strobes", 32'(strobes), 32'd0);    // all low in reset
        end
        @(negedge CLK);
        reset = 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++)
            applyVector(i);

        resetMidInstruction();

        $display("Simulation completed successfully");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before the vector table finished", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule
